// File: Makefile
# Verilator build and run of the adc display testbench

TOP = tb_adc_display

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim 2>&1 | tee run.log
	@if grep -q "Test failed" run.log; then exit 1; fi
	@grep -q "Test passed" run.log

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

// File: logic/adc_display_top.sv
/* adc display top
   i2c converter reader, sample formatter, digit scanner */
`timescale 1ns/1ps
module adc_display_top #(
	parameter int         clk_freq  = 50_000_000,
	parameter int         i2c_freq  = 100_000,
	parameter int         scan_freq = 1000,
	parameter logic [6:0] device_id = 7'b1001000
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       en_read,
	input  logic       sda_in,
	output logic       scl,
	output logic       sda_oe,
	output logic       busy,
	output logic [7:0] adc_data,
	output logic       adc_data_vld,
	output logic       ack_err,
	output logic [7:0] seg_val_out,
	output logic [7:0] seg_sel_out
);

	logic [31:0] seg_val;				// formatted digits
	logic [7:0]  seg_sel;				// digit enables

	adc_reader #(
		.clk_freq  (clk_freq),
		.i2c_freq  (i2c_freq),
		.device_id (device_id)
	) u_adc_reader (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.en_read      (en_read),
		.sda_in       (sda_in),
		.scl          (scl),
		.sda_oe       (sda_oe),
		.busy         (busy),
		.adc_data     (adc_data),
		.adc_data_vld (adc_data_vld),
		.ack_err      (ack_err)
	);

	sample_format u_sample_format (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.adc_data     (adc_data),
		.adc_data_vld (adc_data_vld),
		.seg_val      (seg_val),
		.seg_sel      (seg_sel)
	);

	seg_scan #(
		.clk_freq  (clk_freq),
		.scan_freq (scan_freq)
	) u_seg_scan (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.seg_val     (seg_val),
		.seg_sel     (seg_sel),
		.seg_val_out (seg_val_out),
		.seg_sel_out (seg_sel_out)
	);

endmodule

// File: logic/adc_pkg.sv
/* shared types and helpers for the adc display
   i2c bit-engine opcodes, active-low seven-segment lookup */
package adc_pkg;

	// bit-engine command, one per cmd_vld pulse
	typedef enum logic [2:0] {
		cmd_start     = 3'd0,	// start or repeated start
		cmd_write     = 3'd1,	// shift out wr_data, sample slave ack
		cmd_read_ack  = 3'd2,	// shift in byte, master acks
		cmd_read_nack = 3'd3,	// shift in byte, master nacks (last byte)
		cmd_stop      = 3'd4	// stop condition, bus released
	} i2c_cmd_e;

	// common-anode pattern, bit low lights the segment, bit 7 is dp
	function automatic logic [7:0] seg_code(input logic [3:0] digit);
		case (digit)
			4'h0: return 8'hC0;
			4'h1: return 8'hF9;
			4'h2: return 8'hA4;
			4'h3: return 8'hB0;
			4'h4: return 8'h99;
			4'h5: return 8'h92;
			4'h6: return 8'h82;
			4'h7: return 8'hF8;
			4'h8: return 8'h80;
			4'h9: return 8'h90;
			4'hA: return 8'h88;
			4'hB: return 8'h83;
			4'hC: return 8'hA7;
			4'hD: return 8'hA1;
			4'hE: return 8'h84;
			4'hF: return 8'h8E;
		endcase
	endfunction

endpackage

// File: logic/adc_reader.sv
/* converter sequencer around the i2c bit engine
   per request: address, control byte, repeated start, two reads
   first byte is the stale conversion, second is returned */
`timescale 1ns/1ps
module adc_reader import adc_pkg::*; #(
	parameter int         clk_freq  = 50_000_000,
	parameter int         i2c_freq  = 100_000,
	parameter logic [6:0] device_id = 7'b1001000
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       en_read,			// read request, ignored while busy
	input  logic       sda_in,
	output logic       scl,
	output logic       sda_oe,
	output logic       busy,
	output logic [7:0] adc_data,
	output logic       adc_data_vld,
	output logic       ack_err			// nack seen, transfer aborted
);

	typedef enum logic [1:0] {st_idle, st_issue, st_wait} seq_e;

	seq_e       state;
	logic [2:0] step;					// index into command list
	logic       nack_seen;
	i2c_cmd_e   cmd;
	i2c_cmd_e   step_cmd;
	logic       cmd_vld;
	logic [7:0] wr_data;
	logic [7:0] step_data;
	logic       ready;
	logic       done;
	logic [7:0] rd_data;
	logic       rd_data_vld;
	logic       ack_ok;

	// command list
	always_comb begin
		step_data = 8'h00;				// control byte, channel 0
		case (step)
			3'd0:    step_cmd = cmd_start;
			3'd1: begin
				step_cmd  = cmd_write;
				step_data = {device_id, 1'b0};	// address, write
			end
			3'd2:    step_cmd = cmd_write;
			3'd3:    step_cmd = cmd_start;	// repeated start
			3'd4: begin
				step_cmd  = cmd_write;
				step_data = {device_id, 1'b1};	// address, read
			end
			3'd5:    step_cmd = cmd_read_ack;	// stale byte
			3'd6:    step_cmd = cmd_read_nack;	// fresh sample
			default: step_cmd = cmd_stop;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state        <= st_idle;
			step         <= '0;
			nack_seen    <= 1'b0;
			cmd_vld      <= 1'b0;
			busy         <= 1'b0;
			adc_data_vld <= 1'b0;
			ack_err      <= 1'b0;
		end else begin
			cmd_vld      <= 1'b0;
			adc_data_vld <= 1'b0;
			ack_err      <= 1'b0;
			case (state)
				st_idle: if (en_read) begin
					busy      <= 1'b1;
					step      <= '0;
					nack_seen <= 1'b0;
					state     <= st_issue;
				end
				st_issue: if (ready) begin
					cmd_vld <= 1'b1;
					state   <= st_wait;
				end
				default: if (done) begin	// st_wait
					state <= st_issue;
					if (step == 3'd7) begin
						busy         <= 1'b0;
						adc_data_vld <= !nack_seen;
						ack_err      <= nack_seen;
						state        <= st_idle;
					end else if (step_cmd == cmd_write && !ack_ok) begin
						nack_seen <= 1'b1;
						step      <= 3'd7;		// abort with stop
					end else begin
						step <= step + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == st_issue && ready) begin
			cmd     <= step_cmd;
			wr_data <= step_data;
		end
		if (done && rd_data_vld && step_cmd == cmd_read_nack)
			adc_data <= rd_data;
	end

	i2c_master #(
		.clk_freq (clk_freq),
		.i2c_freq (i2c_freq)
	) u_i2c_master (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.cmd         (cmd),
		.cmd_vld     (cmd_vld),
		.wr_data     (wr_data),
		.sda_in      (sda_in),
		.ready       (ready),
		.done        (done),
		.rd_data     (rd_data),
		.rd_data_vld (rd_data_vld),
		.ack_ok      (ack_ok),
		.scl         (scl),
		.sda_oe      (sda_oe)
	);

endmodule

// File: logic/i2c_master.sv
/* i2c bit engine with cmd/cmd_vld/done handshake
   start, write byte, read byte with ack or nack, stop
   scl and open-drain sda_oe registered, four quarters per bit */
`timescale 1ns/1ps
module i2c_master import adc_pkg::*; #(
	parameter int clk_freq = 50_000_000,
	parameter int i2c_freq = 100_000
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  i2c_cmd_e   cmd,			// opcode, taken with cmd_vld
	input  logic       cmd_vld,		// single cycle, only while ready
	input  logic [7:0] wr_data,		// byte for cmd_write
	input  logic       sda_in,		// wired-and line level
	output logic       ready,		// idle, next command accepted
	output logic       done,		// command finished
	output logic [7:0] rd_data,		// received byte
	output logic       rd_data_vld,	// with done on reads
	output logic       ack_ok,		// slave acked, with done on writes
	output logic       scl,
	output logic       sda_oe		// 1 pulls sda low
);

	localparam int qtr_div = clk_freq / (4 * i2c_freq);			// cycles per quarter bit
	localparam int qtr_w   = (qtr_div > 1) ? $clog2(qtr_div) : 1;

	typedef enum logic [2:0] {st_idle, st_start, st_bit, st_ack, st_stop} state_e;

	state_e           state;
	i2c_cmd_e         cur_cmd;		// latched opcode
	logic [qtr_w-1:0] qtr_cnt;
	logic [1:0]       qtr;			// quarter within the bit slot
	logic [2:0]       bit_cnt;
	logic [7:0]       shreg;		// tx or rx shift register
	logic             qtr_end;
	logic             slot_end;
	logic             sample;
	logic             is_read;
	logic             scl_nxt;
	logic             sda_oe_nxt;

	assign qtr_end  = (qtr_cnt == qtr_w'(qtr_div - 1));
	assign slot_end = qtr_end && (qtr == 2'd3);		// last cycle of the slot
	assign sample   = qtr_end && (qtr == 2'd1);		// middle of scl high
	assign is_read  = (cur_cmd == cmd_read_ack) || (cur_cmd == cmd_read_nack);
	assign ready    = (state == st_idle);

	// line levels per quarter; scl high in quarters 1 and 2
	always_comb begin
		scl_nxt    = scl;			// idle holds lines between commands
		sda_oe_nxt = sda_oe;
		case (state)
			st_start: begin
				scl_nxt    = (qtr == 2'd1) || (qtr == 2'd2);
				sda_oe_nxt = (qtr >= 2'd2);		// sda falls while scl high
			end
			st_bit: begin
				scl_nxt    = (qtr == 2'd1) || (qtr == 2'd2);
				sda_oe_nxt = !is_read && !shreg[7];	// msb first
			end
			st_ack: begin
				scl_nxt    = (qtr == 2'd1) || (qtr == 2'd2);
				sda_oe_nxt = (cur_cmd == cmd_read_ack);	// release for slave ack or nack
			end
			st_stop: begin
				scl_nxt    = (qtr != 2'd0);
				sda_oe_nxt = (qtr <= 2'd1);		// sda rises while scl high
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state       <= st_idle;
			qtr_cnt     <= '0;
			qtr         <= '0;
			bit_cnt     <= '0;
			done        <= 1'b0;
			rd_data_vld <= 1'b0;
			scl         <= 1'b1;		// bus free
			sda_oe      <= 1'b0;
		end else begin
			done        <= 1'b0;
			rd_data_vld <= 1'b0;
			scl         <= scl_nxt;
			sda_oe      <= sda_oe_nxt;
			if (state == st_idle) begin
				qtr_cnt <= '0;
				qtr     <= '0;
				bit_cnt <= '0;
				if (cmd_vld) begin
					case (cmd)
						cmd_start: state <= st_start;
						cmd_stop:  state <= st_stop;
						default:   state <= st_bit;	// write or read byte
					endcase
				end
			end else begin
				qtr_cnt <= qtr_end ? '0 : qtr_cnt + 1'b1;
				if (qtr_end)
					qtr <= qtr + 1'b1;
				if (slot_end) begin
					case (state)
						st_bit: begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 3'd7)
								state <= st_ack;	// ninth clock
						end
						st_ack: begin
							done        <= 1'b1;
							rd_data_vld <= is_read;
							state       <= st_idle;
						end
						default: begin			// start or stop slot
							done  <= 1'b1;
							state <= st_idle;
						end
					endcase
				end
			end
		end
	end

	// datapath
	always_ff @(posedge sys_clk) begin
		if (ready && cmd_vld) begin
			cur_cmd <= cmd;
			shreg   <= wr_data;
		end else if (state == st_bit) begin
			if (is_read && sample)
				shreg <= {shreg[6:0], sda_in};		// rx bit at scl high
			else if (!is_read && slot_end)
				shreg <= {shreg[6:0], 1'b0};		// next tx bit
		end
		if (state == st_ack && sample)
			ack_ok <= !sda_in;					// low means ack
		if (state == st_ack && slot_end)
			rd_data <= shreg;
	end

endmodule

// File: logic/sample_format.sv
/* sample to display digits
   hex in digits 7..6, decimal in digits 2..0 with leading zero blanking */
`timescale 1ns/1ps
module sample_format (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic [7:0]  adc_data,
	input  logic        adc_data_vld,
	output logic [31:0] seg_val,		// digit 7 in top nibble
	output logic [7:0]  seg_sel		// 1 enables the digit
);

	logic [11:0] bcd;				// hundreds, tens, units
	logic        en_tens;
	logic        en_hund;

	// shift-and-add-three, hundreds column never exceeds 2
	function automatic logic [11:0] bin2bcd(input logic [7:0] bin);
		logic [19:0] sh;
		sh = {12'd0, bin};
		for (int i = 0; i < 8; i++) begin
			if (sh[11:8] > 4'd4)
				sh[11:8] = sh[11:8] + 4'd3;
			if (sh[15:12] > 4'd4)
				sh[15:12] = sh[15:12] + 4'd3;
			sh = sh << 1;
		end
		return sh[19:8];
	endfunction

	assign bcd     = bin2bcd(adc_data);
	assign en_tens = (adc_data >= 8'd10);
	assign en_hund = (adc_data >= 8'd100);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			seg_val <= '0;
			seg_sel <= '0;			// all digits dark
		end else if (adc_data_vld) begin
			seg_val <= {adc_data, 12'h000, bcd};	// digits 5..3 unused
			seg_sel <= {2'b11, 3'b000, en_hund, en_tens, 1'b1};
		end
	end

endmodule

// File: logic/seg_scan.sv
/* eight-digit multiplexed scanner
   tick counter, digit index, segment decode, active-low enables */
`timescale 1ns/1ps
module seg_scan import adc_pkg::*; #(
	parameter int clk_freq  = 50_000_000,
	parameter int scan_freq = 1000
) (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic [31:0] seg_val,		// eight nibbles, digit 7 on top
	input  logic [7:0]  seg_sel,		// per-digit enable
	output logic [7:0]  seg_val_out,	// active-low segments
	output logic [7:0]  seg_sel_out	// active-low digit enables
);

	localparam int scan_div = clk_freq / scan_freq;		// cycles per digit
	localparam int cnt_w    = (scan_div > 1) ? $clog2(scan_div) : 1;

	logic [cnt_w-1:0] tick_cnt;
	logic             tick;
	logic [2:0]       sel;					// current digit
	logic [3:0]       nibble;
	logic [7:0]       digit_on;

	assign tick     = (tick_cnt == cnt_w'(scan_div - 1));
	assign nibble   = seg_val[{sel, 2'b00} +: 4];
	assign digit_on = (8'd1 << sel) & seg_sel;		// one-hot, masked by enable

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			tick_cnt <= '0;
			sel      <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
			sel      <= sel + 1'b1;		// wraps 7 to 0
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			seg_val_out <= 8'hFF;		// segments off
			seg_sel_out <= 8'hFF;		// digits off
		end else begin
			seg_val_out <= seg_code(nibble);
			seg_sel_out <= ~digit_on;
		end
	end

endmodule

// File: sources.f
logic/adc_pkg.sv
logic/i2c_master.sv
logic/adc_reader.sv
logic/sample_format.sv
logic/seg_scan.sv
logic/adc_display_top.sv
verif/adc_i2c_model.sv
verif/adc_display_sva.sv
verif/tb_adc_display.sv

// File: verif/adc_display_sva.sv
/* concurrent checks on the converter sequencer
   command handshake, exclusive completion pulses, busy span */
`timescale 1ns/1ps
module adc_display_sva (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic cmd_vld,
	input logic ready,
	input logic en_read,
	input logic busy,
	input logic adc_data_vld,
	input logic ack_err
);

	// commands only offered to an idle bit engine
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n) cmd_vld |-> ready)
		else $error("cmd_vld without ready");

	// one outcome per transfer
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n) !(adc_data_vld && ack_err))
		else $error("adc_data_vld and ack_err together");

	// accepted request raises busy
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n) (en_read && !busy) |=> busy)
		else $error("busy not raised on request");

	// busy only drops at completion
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(busy) |-> (adc_data_vld || ack_err))
		else $error("busy dropped before completion");

endmodule

bind adc_reader adc_display_sva u_sva (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.cmd_vld      (cmd_vld),
	.ready        (ready),
	.en_read      (en_read),
	.busy         (busy),
	.adc_data_vld (adc_data_vld),
	.ack_err      (ack_err)
);

// File: verif/adc_i2c_model.sv
/* behavioral i2c converter slave
   acks its address and control byte, returns a stale byte then the sample
   address nack switch for the error path */
`timescale 1ns/1ps
module adc_i2c_model #(
	parameter logic [6:0] device_id = 7'b1001000
) (
	input  logic       scl,
	input  logic       sda,			// wired-and line
	input  logic [7:0] sample,		// programmed conversion result
	input  logic       nack_addr,	// 1 refuses the address
	output logic       pull			// 1 pulls sda low
);

	logic       active;
	logic       is_addr;			// first byte after a start
	logic       rd_mode;
	logic       addr_ok;
	logic       tx;					// slave is sending
	logic       m_ack;				// master acked last sent byte
	logic [7:0] shreg;
	logic [7:0] tx_byte;
	int         bit_idx;			// -1 right after start, 8 is the ack slot
	int         was;

	initial begin
		pull    = 1'b0;
		active  = 1'b0;
		tx      = 1'b0;
		is_addr = 1'b0;
		rd_mode = 1'b0;
		addr_ok = 1'b0;
		m_ack   = 1'b0;
		bit_idx = -1;
	end

	always @(negedge sda) begin
		if (scl) begin				// start or repeated start
			active  = 1'b1;
			is_addr = 1'b1;
			tx      = 1'b0;
			bit_idx = -1;
			pull    = 1'b0;
		end
	end

	always @(posedge sda) begin
		if (scl) begin				// stop
			active = 1'b0;
			tx     = 1'b0;
			pull   = 1'b0;
		end
	end

	always @(posedge scl) begin
		if (active && !tx && bit_idx >= 0 && bit_idx <= 7)
			shreg = {shreg[6:0], sda};		// msb first
		if (active && tx && bit_idx == 8)
			m_ack = !sda;
	end

	always @(negedge scl) begin
		if (active) begin
			was     = bit_idx;
			bit_idx = (bit_idx == 8) ? 0 : bit_idx + 1;
			if (bit_idx == 8) begin
				pull = 1'b0;			// release for master ack
				if (!tx && is_addr) begin
					addr_ok = (shreg[7:1] == device_id) && !nack_addr;
					rd_mode = shreg[0];
					pull    = addr_ok;
				end else if (!tx) begin
					pull = 1'b1;		// data byte always acked
				end
			end else if (bit_idx == 0 && was == 8) begin
				pull = 1'b0;
				if (!tx) begin
					if (is_addr && !addr_ok)
						active = 1'b0;	// wait for stop
					else if (is_addr && rd_mode) begin
						tx      = 1'b1;
						tx_byte = ~sample;	// stale value, kept distinct
						pull    = !tx_byte[7];
					end
					is_addr = 1'b0;
				end else if (m_ack) begin
					tx_byte = sample;		// fresh conversion
					pull    = !tx_byte[7];
				end else begin
					active = 1'b0;		// master nack ends the read
					tx     = 1'b0;
				end
			end else if (bit_idx >= 1 && bit_idx <= 7) begin
				pull = tx ? !tx_byte[7 - bit_idx] : 1'b0;
			end else begin
				pull = 1'b0;
			end
		end
	end

endmodule

// File: verif/tb_adc_display.sv
/* testbench for the adc display top
   clock, reset, i2c slave model, read requests, reference digits,
   compare process on data and display ports, cycle timeout */
`timescale 1ns/1ps
module tb_adc_display;

	localparam int cycle_limit = 21 * (40 * 40 + 1000) + 20000;	// transfers plus scan waits

	logic       sys_clk;
	logic       sys_rst_n;
	logic       en_read;
	logic       sda_oe;
	logic       scl;
	logic       pull;
	logic       busy;
	logic [7:0] adc_data;
	logic       adc_data_vld;
	logic       ack_err;
	logic [7:0] seg_val_out;
	logic [7:0] seg_sel_out;
	logic [7:0] slave_sample;		// value the model returns
	logic       nack_addr;
	wire        sda = !(sda_oe || pull);	// open-drain wired-and

	int         seed = 32;
	int         cycle_cnt = 0;
	int         req_cnt = 0;		// accepted requests
	int         vld_cnt = 0;
	int         err_cnt = 0;
	logic [7:0] shown;				// sample now on the display
	logic [7:0] shown_next;
	logic       shown_on = 1'b0;
	int         pend = 0;			// cycles until display catches up
	logic [7:0] seen_mask;			// digits selected since last update
	logic [7:0] en_mask;			// expected enables of the shown sample
	int         idx;

	adc_display_top #(
		.clk_freq  (10_000_000),
		.i2c_freq  (250_000),
		.scan_freq (100_000),
		.device_id (7'b1001000)
	) u_adc_display_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.en_read      (en_read),
		.sda_in       (sda),
		.scl          (scl),
		.sda_oe       (sda_oe),
		.busy         (busy),
		.adc_data     (adc_data),
		.adc_data_vld (adc_data_vld),
		.ack_err      (ack_err),
		.seg_val_out  (seg_val_out),
		.seg_sel_out  (seg_sel_out)
	);

	adc_i2c_model #(.device_id(7'b1001000)) u_adc_i2c_model (
		.scl       (scl),
		.sda       (sda),
		.sample    (slave_sample),
		.nack_addr (nack_addr),
		.pull      (pull)
	);

	always #50 sys_clk = ~sys_clk;

	// common-anode pattern of a hex digit
	function automatic logic [7:0] seg_pattern(input logic [3:0] d);
		logic [7:0] table_lo [16];
		table_lo = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
		             8'h80, 8'h90, 8'h88, 8'h83, 8'hA7, 8'hA1, 8'h84, 8'h8E};
		return table_lo[d];
	endfunction

	// digit shown at a position for a sample
	function automatic logic [3:0] exp_digit(input logic [7:0] v, input int pos);
		case (pos)
			7:       return v[7:4];
			6:       return v[3:0];
			2:       return 4'(v / 100);
			1:       return 4'((v / 10) % 10);
			0:       return 4'(v % 10);
			default: return 4'h0;
		endcase
	endfunction

	// enabled digits, leading decimal zeros blanked
	function automatic logic [7:0] exp_mask(input logic [7:0] v);
		return {2'b11, 3'b000, v >= 8'd100, v >= 8'd10, 1'b1};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// compare process, sampled away from the driving edge
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			if (adc_data_vld) begin
				check("adc_data_vld in nack test", {31'd0, nack_addr}, 32'd0);
				check("adc_data", {24'd0, adc_data}, {24'd0, slave_sample});
				vld_cnt++;
				shown_next = slave_sample;
				pend       = 3;		// this edge, formatter, scanner register
			end
			if (ack_err) begin
				check("ack_err without nack", {31'd0, nack_addr}, 32'd1);
				err_cnt++;
			end
			if (pend > 0) begin
				pend--;
				if (pend == 0) begin
					shown     = shown_next;
					shown_on  = 1'b1;
					seen_mask = 8'h00;
				end
			end
			if (!shown_on)
				check("seg_sel_out", {24'd0, seg_sel_out}, 32'hFF);
			else if (seg_sel_out != 8'hFF) begin
				check("seg_sel_out low bits", $countones(~seg_sel_out), 1);
				for (int i = 0; i < 8; i++)
					if (!seg_sel_out[i])
						idx = i;
				en_mask = exp_mask(shown);
				check("enable of selected digit", {31'd0, en_mask[idx]}, 32'd1);
				check("seg_val_out", {24'd0, seg_val_out},
					{24'd0, seg_pattern(exp_digit(shown, idx))});
				seen_mask[idx] = 1'b1;
			end
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: transfers did not finish in %0d cycles", cycle_limit);
			$display("Test failed");
			$fatal(1);
		end
	end

	// one request, optional extra pulses while busy, then a full scan
	task automatic read_sample(input logic [7:0] val, input logic nack, input logic extra);
		@(posedge sys_clk);
		slave_sample <= val;
		nack_addr    <= nack;
		en_read      <= 1'b1;
		req_cnt++;
		@(posedge sys_clk);
		en_read <= 1'b0;
		if (extra) begin
			repeat (5) @(posedge sys_clk);
			en_read <= 1'b1;		// ignored, busy high
			repeat (3) @(posedge sys_clk);
			en_read <= 1'b0;
		end
		do @(posedge sys_clk); while (!(adc_data_vld || ack_err));
		repeat (900) @(posedge sys_clk);	// eight scan steps and slack
		if (!nack)
			check("digits scanned", {24'd0, seen_mask}, {24'd0, exp_mask(val)});
	endtask

	initial begin
		logic [7:0] specials [6];
		specials     = '{8'd0, 8'd9, 8'd10, 8'd99, 8'd100, 8'd255};
		sys_clk      = 1'b0;
		sys_rst_n    = 1'b0;
		en_read      = 1'b0;
		slave_sample = 8'h00;
		nack_addr    = 1'b0;
		repeat (8) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		check("seg_sel_out", {24'd0, seg_sel_out}, 32'hFF);
		check("sda_oe", {31'd0, sda_oe}, 32'd0);
		check("scl", {31'd0, scl}, 32'd1);
		check("busy", {31'd0, busy}, 32'd0);
		check("adc_data_vld", {31'd0, adc_data_vld}, 32'd0);
		check("ack_err", {31'd0, ack_err}, 32'd0);
		for (int i = 0; i < 6; i++)
			read_sample(specials[i], 1'b0, i[0]);
		for (int i = 0; i < 14; i++)
			read_sample(8'($random(seed)), 1'b0, i[0]);
		read_sample(8'($random(seed)), 1'b1, 1'b0);	// address refused
		check("adc_data_vld count", vld_cnt, req_cnt - 1);
		check("ack_err count", err_cnt, 1);
		$display("Test passed");
		$finish;
	end

endmodule
